/* files.f */
sldu_cfg_pkg.sv
sldu_op_pkg.sv
sldu_operand_stage.sv
sldu_shift_net.sv
sldu_result_stage.sv
vsldu_top.sv
vsldu_assertions.sv
tb_vsldu.sv

/* Makefile */
# Verilator build and run for the vector slide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_vsldu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_vsldu.sv */
// ############################
// Directed testbench for the vector slide unit.
// Drives vsldu_top on the falling edge, waits for
// done and compares against an element-wise model.
// ############################
`timescale 1ns/1ps

module tb_vsldu;

    localparam int NUM_OPS     = 100;
    localparam int CYCLE_LIMIT = NUM_OPS * (sldu_cfg_pkg::LATENCY + 4) + 8 + 50;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic [2:0]                          op_instr;
    logic [2:0]                          sew;
    logic [2:0]                          lmul;
    logic [sldu_cfg_pkg::VLEN-1:0]       vs2_1;
    logic [sldu_cfg_pkg::VLEN-1:0]       vs2_2;
    logic [sldu_cfg_pkg::VLEN-1:0]       vs2_3;
    logic [sldu_cfg_pkg::VLEN-1:0]       vs2_4;
    logic [sldu_cfg_pkg::SCALAR_W-1:0]   rs1;
    logic                                done;
    logic [sldu_cfg_pkg::GROUP_W-1:0]    result;
    logic [31:0]                         seed = 32'd83668;
    int                                  cycle_count;

    vsldu_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .op_instr (op_instr),
        .sew      (sew),
        .lmul     (lmul),
        .vs2_1    (vs2_1),
        .vs2_2    (vs2_2),
        .vs2_3    (vs2_3),
        .vs2_4    (vs2_4),
        .rs1      (rs1),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests ran past %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;   // lcg step
        return seed;
    endfunction

    task automatic check_value(input logic [511:0] got, input logic [511:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] elem_at(sldu_op_pkg::vgroup_u g, int eb, int i);
        case (eb)
            4:       return g.e32[i[3:0]];
            2:       return {16'h0, g.e16[i[4:0]]};
            default: return {24'h0, g.e8[i[5:0]]};
        endcase
    endfunction

    // element i of the result, straight from the slide rules
    function automatic logic [511:0] ref_result(input logic [2:0] op, input logic [2:0] s,
                                                input logic [2:0] l, input logic [511:0] regs,
                                                input logic [31:0] r1);
        sldu_op_pkg::vgroup_u src;
        sldu_op_pkg::vgroup_u res;
        int                   eb;
        int                   n;
        int                   off;
        logic [31:0]          v;
        eb  = (s == 3'd1) ? 2 : (s == 3'd2) ? 4 : 1;
        n   = ((l == 3'd1) ? 32 : (l == 3'd2) ? 64 : 16) / eb;
        off = int'(r1[6:0]);
        src = regs;
        for (int b = n * eb; b < 64; b++) src.e8[b[5:0]] = 8'h00;   // registers outside group
        res = '0;
        for (int i = 0; i < n; i++) begin
            case (op)
                sldu_op_pkg::OP_SLIDEUP:    v = (i < off) ? elem_at(src, eb, i)
                                                          : elem_at(src, eb, i - off);
                sldu_op_pkg::OP_SLIDE1UP:   v = (i == 0) ? r1 : elem_at(src, eb, i - 1);
                sldu_op_pkg::OP_SLIDEDOWN:  v = (i + off < n) ? elem_at(src, eb, i + off) : 32'h0;
                sldu_op_pkg::OP_SLIDE1DOWN: v = (i == n - 1) ? r1 : elem_at(src, eb, i + 1);
                default:                    v = (i == 0) ? r1 : 32'h0;   // move scalar
            endcase
            case (eb)
                4:       res.e32[i[3:0]] = v;
                2:       res.e16[i[4:0]] = v[15:0];
                default: res.e8[i[5:0]]  = v[7:0];
            endcase
        end
        return res;
    endfunction

    task automatic load_operands(input logic [2:0] op, input logic [2:0] s,
                                 input logic [2:0] l, input int off);
        logic [31:0] r;
        r        = next_rand();
        vs2_1    = {next_rand(), next_rand(), next_rand(), next_rand()};
        vs2_2    = {next_rand(), next_rand(), next_rand(), next_rand()};
        vs2_3    = {next_rand(), next_rand(), next_rand(), next_rand()};
        vs2_4    = {next_rand(), next_rand(), next_rand(), next_rand()};
        rs1      = {r[31:7], 7'(off)};   // offset in the low bits
        op_instr = op;
        sew      = s;
        lmul     = l;
    endtask

    task automatic run_op(input logic [2:0] op, input logic [2:0] s, input logic [2:0] l,
                          input int off, input string what);
        logic [511:0] expected;
        int           waited;
        @(negedge clk);
        load_operands(op, s, l, off);
        start    = 1'b1;
        expected = ref_result(op, s, l, {vs2_4, vs2_3, vs2_2, vs2_1}, rs1);
        @(negedge clk);
        start  = 1'b0;
        waited = 1;   // one cycle since the strobe
        while (!done) begin
            @(negedge clk);
            waited++;
        end
        check_value(512'(waited), 512'(sldu_cfg_pkg::LATENCY), {what, " latency"});
        check_value(result, expected, what);
    endtask

    task automatic slide_sweep(input logic [2:0] op);
        int n;
        int off;
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 3; l++) begin
                n = (16 << l) >> s;
                for (int k = 0; k < 4; k++) begin
                    off = (k == 3) ? n : (k == 2) ? n / 2 : k;   // 0, 1, mid, whole group
                    run_op(op, 3'(s), 3'(l), off,
                           $sformatf("op %0d sew %0d lmul %0d offset %0d", op, s, l, off));
                end
            end
        end
    endtask

    task automatic scalar_ops();
        logic [31:0] r;
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 3; l++) begin
                r = next_rand();
                run_op(sldu_op_pkg::OP_SLIDE1UP, 3'(s), 3'(l), int'(r[6:0]),
                       $sformatf("slide1up sew %0d lmul %0d", s, l));
                run_op(sldu_op_pkg::OP_SLIDE1DOWN, 3'(s), 3'(l), int'(r[6:0]),
                       $sformatf("slide1down sew %0d lmul %0d", s, l));
            end
            run_op(sldu_op_pkg::OP_VMV, 3'(s), 3'd2, int'(r[6:0]), $sformatf("vmv sew %0d", s));
        end
    endtask

    task automatic reject_invalid_op();
        logic [511:0] kept;
        kept = result;
        @(negedge clk);
        load_operands(3'd5, 3'd0, 3'd0, 9);
        start = 1'b1;
        repeat (sldu_cfg_pkg::LATENCY + 2) begin
            @(negedge clk);
            start = 1'b0;
            check_value(512'(done), 512'd0, "done after invalid op");
        end
        check_value(result, kept, "result after invalid op");
    endtask

    // three strobes in a row, results must come out in order
    task automatic back_to_back();
        logic [511:0] exp_q[$];
        logic [2:0]   ops[3];
        ops[0] = sldu_op_pkg::OP_SLIDEUP;
        ops[1] = sldu_op_pkg::OP_SLIDE1DOWN;
        ops[2] = sldu_op_pkg::OP_VMV;
        for (int t = 0; t < 6; t++) begin
            @(negedge clk);
            if (t >= 1) begin
                check_value(512'(done),
                            512'(t >= sldu_cfg_pkg::LATENCY && t < sldu_cfg_pkg::LATENCY + 3),
                            "back to back done");
            end
            if (t >= sldu_cfg_pkg::LATENCY && t < sldu_cfg_pkg::LATENCY + 3) begin
                check_value(result, exp_q.pop_front(), "back to back result");
            end
            if (t < 3) begin
                load_operands(ops[t[1:0]], 3'(t), 3'd2, 2 + t);
                start = 1'b1;
                exp_q.push_back(ref_result(op_instr, sew, lmul,
                                           {vs2_4, vs2_3, vs2_2, vs2_1}, rs1));
            end else begin
                start = 1'b0;
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        op_instr = '0;
        sew      = '0;
        lmul     = '0;
        vs2_1    = '0;
        vs2_2    = '0;
        vs2_3    = '0;
        vs2_4    = '0;
        rs1      = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_value(512'(done), 512'd0, "done after reset");
        check_value(result, '0, "result after reset");
        slide_sweep(sldu_op_pkg::OP_SLIDEUP);
        slide_sweep(sldu_op_pkg::OP_SLIDEDOWN);
        scalar_ops();
        reject_invalid_op();
        back_to_back();
        // unknown codes fall back to e8 and a single register
        run_op(sldu_op_pkg::OP_SLIDEUP, 3'd7, 3'd7, 3, "default codes slideup");
        run_op(sldu_op_pkg::OP_SLIDE1DOWN, 3'd3, 3'd5, 0, "default codes slide1down");
        $display("Simulation passed");
        $finish;
    end

endmodule

/* vsldu_assertions.sv */
// ############################
// Concurrent checks on the result stage.
// Bound to sldu_result_stage from this file.
// ############################
`timescale 1ns/1ps

module vsldu_assertions (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               valid,
    input logic                               done,
    input logic [sldu_cfg_pkg::GROUP_W-1:0]   result,
    input logic [6:0]                         group_bytes_used
);

    // done twice in a row only for two valid cycles in a row
    assert property (@(posedge clk) disable iff (!rst_n)
        done && $past(done) |-> $past(valid) && $past(valid, 2))
        else $error("done held without two consecutive valid cycles");

    assert property (@(posedge clk) $rose(rst_n) |-> !done)
        else $error("done high in the first cycle after reset");

    // result was written with last cycle's group size
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (result >> {$past(group_bytes_used), 3'b000}) == '0)
        else $error("result bits above the group are not zero");

endmodule

bind sldu_result_stage vsldu_assertions u_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid            (valid),
    .done             (done),
    .result           (result),
    .group_bytes_used (group_bytes_used)
);

/* vsldu_top.sv */
// ############################
// Vector slide unit top level.
// Pulse start with the operands valid in the same
// cycle; done and result follow two cycles later.
// ############################
`timescale 1ns/1ps

module vsldu_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [2:0]                          op_instr,
    input  logic [2:0]                          sew,
    input  logic [2:0]                          lmul,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_1,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_2,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_3,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_4,
    input  logic [sldu_cfg_pkg::SCALAR_W-1:0]   rs1,
    output logic                                done,
    output logic [sldu_cfg_pkg::GROUP_W-1:0]    result
);

    logic                               valid;
    sldu_op_pkg::vgroup_u               src_group;
    sldu_op_pkg::vgroup_u               shifted_group;
    logic [sldu_cfg_pkg::SCALAR_W-1:0]  scalar;
    logic [2:0]                         elem_bytes;
    logic [6:0]                         group_bytes_used;
    logic                               shift_dir;
    logic [8:0]                         shift_bytes;
    logic                               insert_scalar;
    logic [5:0]                         insert_index;

    sldu_operand_stage u_operand (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .op_instr         (op_instr),
        .sew              (sew),
        .lmul             (lmul),
        .vs2_1            (vs2_1),
        .vs2_2            (vs2_2),
        .vs2_3            (vs2_3),
        .vs2_4            (vs2_4),
        .rs1              (rs1),
        .valid            (valid),
        .src_group        (src_group),
        .scalar           (scalar),
        .elem_bytes       (elem_bytes),
        .group_bytes_used (group_bytes_used),
        .shift_dir        (shift_dir),
        .shift_bytes      (shift_bytes),
        .insert_scalar    (insert_scalar),
        .insert_index     (insert_index)
    );

    sldu_shift_net u_shift (
        .src_group     (src_group),
        .shift_dir     (shift_dir),
        .shift_bytes   (shift_bytes),
        .shifted_group (shifted_group)
    );

    sldu_result_stage u_result (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid            (valid),
        .src_group        (src_group),
        .shifted_group    (shifted_group),
        .scalar           (scalar),
        .elem_bytes       (elem_bytes),
        .group_bytes_used (group_bytes_used),
        .shift_dir        (shift_dir),
        .shift_bytes      (shift_bytes),
        .insert_scalar    (insert_scalar),
        .insert_index     (insert_index),
        .done             (done),
        .result           (result)
    );

endmodule

/* sldu_result_stage.sv */
// ############################
// Last pipeline stage of the slide unit.
// Picks source or shifted bytes, drops the scalar
// into its element at the current sew and clears
// everything above the group. Result and done
// are registered on valid.
// ############################
`timescale 1ns/1ps

module sldu_result_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                valid,
    input  sldu_op_pkg::vgroup_u                src_group,
    input  sldu_op_pkg::vgroup_u                shifted_group,
    input  logic [sldu_cfg_pkg::SCALAR_W-1:0]   scalar,
    input  logic [2:0]                          elem_bytes,
    input  logic [6:0]                          group_bytes_used,
    input  logic                                shift_dir,
    input  logic [8:0]                          shift_bytes,
    input  logic                                insert_scalar,
    input  logic [5:0]                          insert_index,
    output logic                                done,
    output sldu_op_pkg::vgroup_u                result
);

    localparam int HALF_IDX_W = $clog2(sldu_cfg_pkg::GROUP_W / 16);
    localparam int WORD_IDX_W = $clog2(sldu_cfg_pkg::GROUP_W / 32);

    sldu_op_pkg::vgroup_u merged;

    always_comb begin
        merged = shifted_group;
        // slide up keeps the source below the offset
        if (!shift_dir) begin
            for (int b = 0; b < sldu_cfg_pkg::GROUP_BYTES; b++) begin
                if (9'(b) < shift_bytes) begin
                    merged.e8[b] = src_group.e8[b];
                end
            end
        end
        if (insert_scalar) begin
            case (elem_bytes)
                3'd4:    merged.e32[insert_index[WORD_IDX_W-1:0]] = scalar;
                3'd2:    merged.e16[insert_index[HALF_IDX_W-1:0]] = scalar[15:0];
                default: merged.e8[insert_index] = scalar[7:0];
            endcase
        end
        for (int b = 0; b < sldu_cfg_pkg::GROUP_BYTES; b++) begin
            if (7'(b) >= group_bytes_used) begin
                merged.e8[b] = 8'h00;   // above the group
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= valid;
            if (valid) begin
                result <= merged;   // held until the next op
            end
        end
    end

endmodule

/* sldu_shift_net.sv */
// ############################
// Byte barrel shifter over one register group.
// Purely combinational, sits between the operand
// and result stages. Zero fill on both sides.
// ############################
`timescale 1ns/1ps

module sldu_shift_net (
    input  sldu_op_pkg::vgroup_u  src_group,
    input  logic                  shift_dir,      // high shifts toward byte 0
    input  logic [8:0]            shift_bytes,
    output sldu_op_pkg::vgroup_u  shifted_group
);

    localparam int AMT_BITS = $clog2(sldu_cfg_pkg::GROUP_BYTES);

    logic [sldu_cfg_pkg::GROUP_W-1:0] work;

    // one stage per amount bit, stage k moves by 2**k bytes
    always_comb begin
        work = src_group;
        for (int k = 0; k < AMT_BITS; k++) begin
            if (shift_bytes[k]) begin
                if (shift_dir) begin
                    work = work >> (8 << k);
                end else begin
                    work = work << (8 << k);
                end
            end
        end
        if (|shift_bytes[8:AMT_BITS]) begin
            work = '0;   // a whole group or more shifts everything out
        end
        shifted_group = work;
    end

endmodule

/* sldu_operand_stage.sv */
// ############################
// First pipeline stage of the slide unit.
// Captures the register group and rs1 on start
// and turns op, sew and lmul into byte-level
// controls for the shifter and result merge.
// ############################
`timescale 1ns/1ps

module sldu_operand_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [2:0]                          op_instr,
    input  logic [2:0]                          sew,
    input  logic [2:0]                          lmul,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_1,        // lowest register
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_2,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_3,
    input  logic [sldu_cfg_pkg::VLEN-1:0]       vs2_4,
    input  logic [sldu_cfg_pkg::SCALAR_W-1:0]   rs1,
    output logic                                valid,
    output sldu_op_pkg::vgroup_u                src_group,
    output logic [sldu_cfg_pkg::SCALAR_W-1:0]   scalar,
    output logic [2:0]                          elem_bytes,
    output logic [6:0]                          group_bytes_used,
    output logic                                shift_dir,    // high moves toward element 0
    output logic [8:0]                          shift_bytes,
    output logic                                insert_scalar,
    output logic [5:0]                          insert_index
);

    localparam int REG_BYTES = sldu_cfg_pkg::VLEN / 8;

    logic [1:0]                              elem_shift;  // log2 of element bytes
    logic [sldu_cfg_pkg::MAX_GROUP_REGS-1:0] reg_en;
    logic [6:0]                              grp_bytes;
    logic [6:0]                              n_elems;
    logic [8:0]                              off_bytes;
    logic [2:0]                              eb;
    logic                                    op_ok;
    logic                                    dir;
    logic                                    ins;
    logic [8:0]                              amt;
    logic [5:0]                              ins_idx;
    sldu_op_pkg::vgroup_u                    src_next;

    always_comb begin
        case (sew)
            sldu_op_pkg::SEW_8:  elem_shift = 2'd0;
            sldu_op_pkg::SEW_16: elem_shift = 2'd1;
            sldu_op_pkg::SEW_32: elem_shift = 2'd2;
            default:             elem_shift = 2'd0;   // unknown sew acts as e8
        endcase
        case (lmul)
            sldu_op_pkg::LMUL_2: reg_en = 4'b0011;
            sldu_op_pkg::LMUL_4: reg_en = 4'b1111;
            default:             reg_en = 4'b0001;    // LMUL_1 and unknown codes
        endcase
        grp_bytes = 7'($countones(reg_en) * REG_BYTES);
        n_elems   = grp_bytes >> elem_shift;
        off_bytes = 9'(rs1[sldu_cfg_pkg::OFFSET_W-1:0]) << elem_shift;
        eb        = 3'b001 << elem_shift;

        // registers outside the group never reach the shifter
        src_next = {vs2_4 & {sldu_cfg_pkg::VLEN{reg_en[3]}},
                    vs2_3 & {sldu_cfg_pkg::VLEN{reg_en[2]}},
                    vs2_2 & {sldu_cfg_pkg::VLEN{reg_en[1]}},
                    vs2_1};

        op_ok   = 1'b1;
        dir     = 1'b0;
        amt     = off_bytes;
        ins     = 1'b0;
        ins_idx = 6'd0;
        case (op_instr)
            sldu_op_pkg::OP_SLIDE1UP: begin
                amt = {6'd0, eb};
                ins = 1'b1;
            end
            sldu_op_pkg::OP_SLIDEUP: ;
            sldu_op_pkg::OP_SLIDE1DOWN: begin
                dir     = 1'b1;
                amt     = {6'd0, eb};
                ins     = 1'b1;
                ins_idx = 6'(n_elems - 7'd1);   // last element of the group
            end
            sldu_op_pkg::OP_SLIDEDOWN: dir = 1'b1;
            sldu_op_pkg::OP_VMV: begin
                dir = 1'b1;
                amt = 9'(sldu_cfg_pkg::GROUP_BYTES);   // shifts everything out
                ins = 1'b1;
            end
            default: op_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= start && op_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (start && op_ok) begin
            src_group        <= src_next;
            scalar           <= rs1;
            elem_bytes       <= eb;
            group_bytes_used <= grp_bytes;
            shift_dir        <= dir;
            shift_bytes      <= amt;
            insert_scalar    <= ins;
            insert_index     <= ins_idx;
        end
    end

endmodule

/* sldu_op_pkg.sv */
// ############################
// Operation and element-width encodings of the
// slide unit, plus the register-group word that
// is read per byte, halfword or word by sew.
// ############################
package sldu_op_pkg;

    typedef enum logic [2:0] {
        OP_SLIDE1UP   = 3'd0,
        OP_SLIDEUP    = 3'd1,
        OP_SLIDE1DOWN = 3'd2,
        OP_SLIDEDOWN  = 3'd3,
        OP_VMV        = 3'd4    // 5 to 7 are not valid
    } sldu_op_e;

    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2
    } sew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2
    } lmul_e;

    // one register group, element 0 in the low bits
    typedef union packed {
        logic [sldu_cfg_pkg::GROUP_BYTES-1:0][7:0]   e8;
        logic [sldu_cfg_pkg::GROUP_W/16-1:0][15:0]   e16;
        logic [sldu_cfg_pkg::GROUP_W/32-1:0][31:0]   e32;
    } vgroup_u;

endpackage

/* sldu_cfg_pkg.sv */
// ############################
// Sizing constants for the vector slide unit.
// Every file refers to them by scoped name,
// e.g. sldu_cfg_pkg::GROUP_W.
// ############################
package sldu_cfg_pkg;

    localparam int VLEN           = 128;                   // bits per vector register
    localparam int MAX_GROUP_REGS = 4;                     // lmul of 4 at most
    localparam int GROUP_W        = VLEN * MAX_GROUP_REGS;
    localparam int GROUP_BYTES    = GROUP_W / 8;           // 64 byte lanes
    localparam int OFFSET_W       = 7;                     // offset bits taken from rs1
    localparam int SCALAR_W       = 32;
    localparam int LATENCY        = 2;                     // start to done, in cycles

endpackage
